// File: rtl/exu_cfg_pkg.sv
`default_nettype none

package exu_cfg_pkg;

   // data path and register file geometry
   localparam int grlen      = 32;
   localparam int reg_addr_w = 5;

   // raw instruction word
   localparam int inst_w = 32;

   // low bit of each register field in the instruction word
   localparam int rd_lsb = 0;
   localparam int rj_lsb = 5;
   localparam int rk_lsb = 10;

   // one general register value
   typedef logic [grlen-1:0] data_t;

   // register number, r0 reads as zero and is never written
   typedef logic [reg_addr_w-1:0] reg_addr_t;

endpackage

`default_nettype wire

// File: rtl/exu_op_pkg.sv
`default_nettype none

package exu_op_pkg;

   localparam int unit_w = 2;
   localparam int code_w = 4;

   // unit class, picks the execution unit that takes the instruction
   typedef enum logic [unit_w-1:0] {
      unit_alu = 2'd0,
      unit_bru = 2'd1,
      unit_lsu = 2'd2
   } unit_e;

   // operation codes, carried to the units unchanged

   // alu operation
   typedef logic [code_w-1:0] alu_code_t;

   // branch condition
   typedef logic [code_w-1:0] bru_code_t;

   // load/store size and sign
   typedef logic [code_w-1:0] lsu_code_t;

endpackage

`default_nettype wire

// File: rtl/exu_dispatch.sv
`default_nettype none

module exu_dispatch (
   input  wire logic                   clk,
   input  wire logic                   rst,
   input  wire logic                   valid_d,
   input  wire logic [exu_cfg_pkg::inst_w-1:0] inst_d,
   input  exu_cfg_pkg::data_t          pc_d,
   input  exu_op_pkg::unit_e           unit_d,
   input  exu_op_pkg::alu_code_t       alu_code_d,
   input  exu_op_pkg::bru_code_t       bru_code_d,
   input  exu_op_pkg::lsu_code_t       lsu_code_d,
   input  wire logic                   a_pc_d,
   input  wire logic                   b_imm_d,
   input  wire logic                   rd2rj_d,
   input  wire logic                   rd_read_d,
   input  wire logic                   double_read_d,
   input  wire logic                   rf_wen_d,
   input  exu_cfg_pkg::reg_addr_t      rf_target_d,
   input  exu_cfg_pkg::data_t          imm_d,
   input  exu_cfg_pkg::data_t          br_offs_d,
   input  exu_cfg_pkg::data_t          rs1_data_d,
   input  exu_cfg_pkg::data_t          rs2_data_d,
   input  wire logic                   kill_e,

   output exu_cfg_pkg::reg_addr_t      rs1_d,
   output exu_cfg_pkg::reg_addr_t      rs2_d,
   output logic                        alu_valid_e,
   output logic                        bru_valid_e,
   output logic                        lsu_valid_e,
   output logic                        lsu_dispatch_d,
   output exu_op_pkg::alu_code_t       alu_code_e,
   output exu_op_pkg::bru_code_t       bru_code_e,
   output exu_op_pkg::lsu_code_t       lsu_code_e,
   output exu_cfg_pkg::data_t          opa_e,
   output exu_cfg_pkg::data_t          opb_e,
   output exu_cfg_pkg::data_t          imm_e,
   output exu_cfg_pkg::data_t          pc_e,
   output exu_cfg_pkg::data_t          br_offs_e,
   output exu_cfg_pkg::reg_addr_t      rs1_e,
   output exu_cfg_pkg::reg_addr_t      rs2_e,
   output exu_cfg_pkg::reg_addr_t      rf_target_e,
   output logic                        rf_wen_alu_e,
   output logic                        lsu_wen_e,
   output logic                        use_other_e
);

   logic                   inst_vld_d;
   logic                   alu_dispatch_d;
   logic                   bru_dispatch_d;
   logic                   b_imm_sel_d;
   exu_cfg_pkg::data_t     opa_d;
   exu_cfg_pkg::data_t     opb_d;
   exu_cfg_pkg::reg_addr_t rs1_fwd_d;

   // a taken branch in E squashes whatever sits in D
   assign inst_vld_d     = valid_d & ~kill_e;
   assign alu_dispatch_d = inst_vld_d & (unit_d == exu_op_pkg::unit_alu);
   assign bru_dispatch_d = inst_vld_d & (unit_d == exu_op_pkg::unit_bru);
   assign lsu_dispatch_d = inst_vld_d & (unit_d == exu_op_pkg::unit_lsu);

   // register file read addresses
   assign rs1_d = rd2rj_d ? inst_d[exu_cfg_pkg::rd_lsb +: exu_cfg_pkg::reg_addr_w]
                          : inst_d[exu_cfg_pkg::rj_lsb +: exu_cfg_pkg::reg_addr_w];
   assign rs2_d = rd_read_d ? inst_d[exu_cfg_pkg::rd_lsb +: exu_cfg_pkg::reg_addr_w]
                            : inst_d[exu_cfg_pkg::rk_lsb +: exu_cfg_pkg::reg_addr_w];

   // operand choice, immediate only for alu work
   assign b_imm_sel_d = b_imm_d & alu_dispatch_d;
   assign opa_d       = a_pc_d ? pc_d : rs1_data_d;
   assign opb_d       = b_imm_sel_d ? imm_d : rs2_data_d;

   // pc operand carries r0 as source so the bypass leaves it alone
   assign rs1_fwd_d = a_pc_d ? '0 : rs1_d;

   //////////////////////////////////////////////////////////////////////
   // D to E
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         alu_valid_e  <= 1'b0;
         bru_valid_e  <= 1'b0;
         lsu_valid_e  <= 1'b0;
         rf_wen_alu_e <= 1'b0;
         lsu_wen_e    <= 1'b0;
      end else begin
         alu_valid_e  <= alu_dispatch_d;
         bru_valid_e  <= bru_dispatch_d;
         lsu_valid_e  <= lsu_dispatch_d;
         rf_wen_alu_e <= rf_wen_d & (unit_d == exu_op_pkg::unit_alu);
         lsu_wen_e    <= rf_wen_d & lsu_dispatch_d;
      end
   end

   // payload, follows the strobes above
   always_ff @(posedge clk) begin
      alu_code_e  <= alu_code_d;
      bru_code_e  <= bru_code_d;
      lsu_code_e  <= lsu_code_d;
      opa_e       <= opa_d;
      opb_e       <= opb_d;
      imm_e       <= imm_d;
      pc_e        <= pc_d;
      br_offs_e   <= br_offs_d;
      rs1_e       <= rs1_fwd_d;
      rs2_e       <= rs2_d;
      rf_target_e <= rf_target_d;
      // rs2 slot holds something other than a register read
      use_other_e <= b_imm_sel_d | (double_read_d & lsu_dispatch_d);
   end

endmodule

`default_nettype wire

// File: rtl/exu_bypass.sv
`default_nettype none

module exu_bypass (
   input  exu_cfg_pkg::data_t     opa_e,
   input  exu_cfg_pkg::data_t     opb_e,
   input  exu_cfg_pkg::data_t     imm_e,
   input  exu_cfg_pkg::data_t     rd_data_m,
   input  exu_cfg_pkg::data_t     rd_data_w,
   input  exu_cfg_pkg::reg_addr_t rs1_e,
   input  exu_cfg_pkg::reg_addr_t rs2_e,
   input  exu_cfg_pkg::reg_addr_t rd_m,
   input  exu_cfg_pkg::reg_addr_t rd_w,
   input  wire logic              wen_m,
   input  wire logic              wen_w,
   input  wire logic              use_other_e,

   output exu_cfg_pkg::data_t     src_a_e,
   output exu_cfg_pkg::data_t     src_b_e,
   output exu_cfg_pkg::data_t     lsu_offset_e
);

   logic live_m;
   logic live_w;
   logic a_sel_m;
   logic a_sel_w;
   logic b_sel_m;
   logic b_sel_w;

   // r0 writes never reach a consumer
   assign live_m = wen_m & (rd_m != '0);
   assign live_w = wen_w & (rd_w != '0);

   //////////////////////////////////////////////////////////////////////
   // operand A
   //////////////////////////////////////////////////////////////////////

   assign a_sel_m = live_m & (rd_m == rs1_e);
   assign a_sel_w = live_w & (rd_w == rs1_e) & ~a_sel_m;

   always_comb begin
      if (a_sel_m) begin
         src_a_e = rd_data_m;
      end else if (a_sel_w) begin
         src_a_e = rd_data_w;
      end else begin
         src_a_e = opa_e;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // operand B
   //////////////////////////////////////////////////////////////////////

   // immediate or indexed slot keeps its registered value
   assign b_sel_m = ~use_other_e & live_m & (rd_m == rs2_e);
   assign b_sel_w = ~use_other_e & live_w & (rd_w == rs2_e) & ~b_sel_m;

   always_comb begin
      if (b_sel_m) begin
         src_b_e = rd_data_m;
      end else if (b_sel_w) begin
         src_b_e = rd_data_w;
      end else begin
         src_b_e = opb_e;
      end
   end

   // indexed access takes B, otherwise the immediate
   assign lsu_offset_e = use_other_e ? src_b_e : imm_e;

endmodule

`default_nettype wire

// File: rtl/exu_writeback.sv
`default_nettype none

module exu_writeback (
   input  wire logic              clk,
   input  wire logic              rst,
   input  wire logic              alu_valid_e,
   input  wire logic              rf_wen_alu_e,
   input  exu_cfg_pkg::reg_addr_t rf_target_e,
   input  exu_cfg_pkg::data_t     alu_res_e,
   input  exu_cfg_pkg::data_t     bru_link_e,
   input  exu_cfg_pkg::data_t     lsu_rdata_m,
   input  wire logic              bru_wen_e,
   input  wire logic              lsu_rdata_valid_m,
   input  wire logic              lsu_wen_m,
   input  wire logic              lsu_dispatch_d,
   input  exu_cfg_pkg::reg_addr_t lsu_rd_m,

   output exu_cfg_pkg::reg_addr_t rd_m,
   output exu_cfg_pkg::reg_addr_t rd_w,
   output exu_cfg_pkg::data_t     rd_data_m,
   output exu_cfg_pkg::data_t     rd_data_w,
   output logic                   wen_m,
   output logic                   wen_w,
   output logic                   stall_req
);

   logic                   alu_wen_m;
   logic                   bru_wen_m;
   exu_cfg_pkg::reg_addr_t rf_target_m;
   exu_cfg_pkg::data_t     alu_res_m;
   exu_cfg_pkg::data_t     bru_link_m;
   logic                   lsu_busy;

   //////////////////////////////////////////////////////////////////////
   // E to M
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         alu_wen_m <= 1'b0;
         bru_wen_m <= 1'b0;
      end else begin
         alu_wen_m <= alu_valid_e & rf_wen_alu_e;
         bru_wen_m <= bru_wen_e;
      end
   end

   // branch link shares the alu target
   always_ff @(posedge clk) begin
      rf_target_m <= rf_target_e;
      alu_res_m   <= alu_res_e;
      bru_link_m  <= bru_link_e;
   end

   // load return has its own destination and arrives at M
   assign rd_m = lsu_rdata_valid_m ? lsu_rd_m : rf_target_m;

   always_comb begin
      if (lsu_rdata_valid_m) begin
         rd_data_m = lsu_rdata_m;
      end else if (bru_wen_m) begin
         rd_data_m = bru_link_m;
      end else begin
         rd_data_m = alu_res_m;
      end
   end

   // any unit may claim the write port
   assign wen_m = alu_wen_m | bru_wen_m | (lsu_wen_m & lsu_rdata_valid_m);

   //////////////////////////////////////////////////////////////////////
   // M to W
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         wen_w <= 1'b0;
      end else begin
         wen_w <= wen_m;
      end
   end

   always_ff @(posedge clk) begin
      rd_w      <= rd_m;
      rd_data_w <= rd_data_m;
   end

   // load/store outstanding, set by dispatch and cleared by the return
   always_ff @(posedge clk) begin
      if (rst) begin
         lsu_busy <= 1'b0;
      end else begin
         lsu_busy <= lsu_dispatch_d | (lsu_busy & ~lsu_rdata_valid_m);
      end
   end

   // covers the dispatch cycle through the return cycle
   assign stall_req = lsu_dispatch_d | lsu_busy;

endmodule

`default_nettype wire

// File: rtl/exu_ecl.sv
`default_nettype none

module exu_ecl (
   input  wire logic                   clk,
   input  wire logic                   rst,

   // decode stage
   input  wire logic                   valid_d,
   input  wire logic [exu_cfg_pkg::inst_w-1:0] inst_d,
   input  exu_cfg_pkg::data_t          pc_d,
   input  exu_op_pkg::unit_e           unit_d,
   input  exu_op_pkg::alu_code_t       alu_code_d,
   input  exu_op_pkg::bru_code_t       bru_code_d,
   input  exu_op_pkg::lsu_code_t       lsu_code_d,
   input  wire logic                   a_pc_d,
   input  wire logic                   b_imm_d,
   input  wire logic                   rd2rj_d,
   input  wire logic                   rd_read_d,
   input  wire logic                   double_read_d,
   input  wire logic                   rf_wen_d,
   input  exu_cfg_pkg::reg_addr_t      rf_target_d,
   input  exu_cfg_pkg::data_t          imm_d,
   input  exu_cfg_pkg::data_t          br_offs_d,
   input  exu_cfg_pkg::data_t          rs1_data_d,
   input  exu_cfg_pkg::data_t          rs2_data_d,
   output exu_cfg_pkg::reg_addr_t      rs1_d,
   output exu_cfg_pkg::reg_addr_t      rs2_d,

   // alu
   output logic                        alu_valid_e,
   output exu_op_pkg::alu_code_t       alu_code_e,
   output exu_cfg_pkg::data_t          alu_a_e,
   output exu_cfg_pkg::data_t          alu_b_e,
   input  exu_cfg_pkg::data_t          alu_res_e,

   // branch unit
   output logic                        bru_valid_e,
   output exu_op_pkg::bru_code_t       bru_code_e,
   output exu_cfg_pkg::data_t          bru_a_e,
   output exu_cfg_pkg::data_t          bru_b_e,
   output exu_cfg_pkg::data_t          bru_pc_e,
   output exu_cfg_pkg::data_t          bru_offs_e,
   input  exu_cfg_pkg::data_t          bru_target_e,
   input  wire logic                   bru_taken_e,
   input  exu_cfg_pkg::data_t          bru_link_e,
   input  wire logic                   bru_wen_e,

   // load/store unit
   output logic                        lsu_valid_e,
   output exu_op_pkg::lsu_code_t       lsu_code_e,
   output exu_cfg_pkg::data_t          lsu_base_e,
   output exu_cfg_pkg::data_t          lsu_offset_e,
   output exu_cfg_pkg::data_t          lsu_wdata_e,
   output exu_cfg_pkg::reg_addr_t      lsu_rd_e,
   output logic                        lsu_wen_e,
   input  wire logic                   lsu_rdata_valid_m,
   input  exu_cfg_pkg::data_t          lsu_rdata_m,
   input  exu_cfg_pkg::reg_addr_t      lsu_rd_m,
   input  wire logic                   lsu_wen_m,

   // fetch and register file
   output logic                        br_taken_e,
   output exu_cfg_pkg::data_t          br_pc_e,
   output logic                        stall_req,
   output logic                        rf_wen_w,
   output exu_cfg_pkg::reg_addr_t      rf_rd_w,
   output exu_cfg_pkg::data_t          rf_rd_data_w
);

   logic                   kill_e;
   logic                   lsu_dispatch_d;
   logic                   rf_wen_alu_e;
   logic                   use_other_e;
   logic                   wen_m;
   exu_cfg_pkg::data_t     opa_e;
   exu_cfg_pkg::data_t     opb_e;
   exu_cfg_pkg::data_t     imm_e;
   exu_cfg_pkg::data_t     src_a_e;
   exu_cfg_pkg::data_t     src_b_e;
   exu_cfg_pkg::data_t     rd_data_m;
   exu_cfg_pkg::reg_addr_t rs1_e;
   exu_cfg_pkg::reg_addr_t rs2_e;
   exu_cfg_pkg::reg_addr_t rd_m;

   // taken branch redirects fetch and squashes D
   assign kill_e     = bru_valid_e & bru_taken_e;
   assign br_taken_e = kill_e;
   assign br_pc_e    = bru_target_e;

   // all units read the same forwarded operands
   assign alu_a_e     = src_a_e;
   assign alu_b_e     = src_b_e;
   assign bru_a_e     = src_a_e;
   assign bru_b_e     = src_b_e;
   assign lsu_base_e  = src_a_e;
   assign lsu_wdata_e = src_b_e;

   exu_dispatch u_dispatch (
      .clk            (clk),
      .rst            (rst),
      .valid_d        (valid_d),
      .inst_d         (inst_d),
      .pc_d           (pc_d),
      .unit_d         (unit_d),
      .alu_code_d     (alu_code_d),
      .bru_code_d     (bru_code_d),
      .lsu_code_d     (lsu_code_d),
      .a_pc_d         (a_pc_d),
      .b_imm_d        (b_imm_d),
      .rd2rj_d        (rd2rj_d),
      .rd_read_d      (rd_read_d),
      .double_read_d  (double_read_d),
      .rf_wen_d       (rf_wen_d),
      .rf_target_d    (rf_target_d),
      .imm_d          (imm_d),
      .br_offs_d      (br_offs_d),
      .rs1_data_d     (rs1_data_d),
      .rs2_data_d     (rs2_data_d),
      .kill_e         (kill_e),
      .rs1_d          (rs1_d),
      .rs2_d          (rs2_d),
      .alu_valid_e    (alu_valid_e),
      .bru_valid_e    (bru_valid_e),
      .lsu_valid_e    (lsu_valid_e),
      .lsu_dispatch_d (lsu_dispatch_d),
      .alu_code_e     (alu_code_e),
      .bru_code_e     (bru_code_e),
      .lsu_code_e     (lsu_code_e),
      .opa_e          (opa_e),
      .opb_e          (opb_e),
      .imm_e          (imm_e),
      .pc_e           (bru_pc_e),
      .br_offs_e      (bru_offs_e),
      .rs1_e          (rs1_e),
      .rs2_e          (rs2_e),
      .rf_target_e    (lsu_rd_e),
      .rf_wen_alu_e   (rf_wen_alu_e),
      .lsu_wen_e      (lsu_wen_e),
      .use_other_e    (use_other_e)
   );

   exu_bypass u_bypass (
      .opa_e        (opa_e),
      .opb_e        (opb_e),
      .imm_e        (imm_e),
      .rd_data_m    (rd_data_m),
      .rd_data_w    (rf_rd_data_w),
      .rs1_e        (rs1_e),
      .rs2_e        (rs2_e),
      .rd_m         (rd_m),
      .rd_w         (rf_rd_w),
      .wen_m        (wen_m),
      .wen_w        (rf_wen_w),
      .use_other_e  (use_other_e),
      .src_a_e      (src_a_e),
      .src_b_e      (src_b_e),
      .lsu_offset_e (lsu_offset_e)
   );

   // E target is shared by alu, branch link and load/store
   exu_writeback u_writeback (
      .clk               (clk),
      .rst               (rst),
      .alu_valid_e       (alu_valid_e),
      .rf_wen_alu_e      (rf_wen_alu_e),
      .rf_target_e       (lsu_rd_e),
      .alu_res_e         (alu_res_e),
      .bru_link_e        (bru_link_e),
      .lsu_rdata_m       (lsu_rdata_m),
      .bru_wen_e         (bru_wen_e),
      .lsu_rdata_valid_m (lsu_rdata_valid_m),
      .lsu_wen_m         (lsu_wen_m),
      .lsu_dispatch_d    (lsu_dispatch_d),
      .lsu_rd_m          (lsu_rd_m),
      .rd_m              (rd_m),
      .rd_w              (rf_rd_w),
      .rd_data_m         (rd_data_m),
      .rd_data_w         (rf_rd_data_w),
      .wen_m             (wen_m),
      .wen_w             (rf_wen_w),
      .stall_req         (stall_req)
   );

endmodule

`default_nettype wire

// File: testbench/exu_ecl_tb.sv
`default_nettype none

module exu_ecl_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          clk_half        = 20;
   localparam int          reset_cycles    = 5;
   localparam int          cycles_per_line = 60;
   localparam int          max_lines       = 64;
   localparam logic [31:0] lfsr_seed       = 32'h68bf274f;
   localparam logic [31:0] lfsr_taps       = 32'h80200003;

   logic clk;
   logic rst;
   logic valid_d, a_pc_d, b_imm_d, rd2rj_d, rd_read_d, double_read_d, rf_wen_d;
   logic [exu_cfg_pkg::inst_w-1:0] inst_d;
   exu_cfg_pkg::data_t pc_d, imm_d, br_offs_d, rs1_data_d, rs2_data_d;
   exu_op_pkg::unit_e unit_d;
   exu_op_pkg::alu_code_t alu_code_d, alu_code_e;
   exu_op_pkg::bru_code_t bru_code_d, bru_code_e;
   exu_op_pkg::lsu_code_t lsu_code_d, lsu_code_e;
   exu_cfg_pkg::reg_addr_t rf_target_d, rs1_d, rs2_d, lsu_rd_e, lsu_rd_m, rf_rd_w;
   logic alu_valid_e, bru_valid_e, lsu_valid_e, lsu_wen_e, br_taken_e, stall_req, rf_wen_w;
   logic bru_taken_e, bru_wen_e, lsu_rdata_valid_m, lsu_wen_m;
   exu_cfg_pkg::data_t alu_a_e, alu_b_e, alu_res_e, bru_a_e, bru_b_e, bru_pc_e, bru_offs_e;
   exu_cfg_pkg::data_t bru_target_e, bru_link_e, lsu_base_e, lsu_offset_e, lsu_wdata_e;
   exu_cfg_pkg::data_t lsu_rdata_m, br_pc_e, rf_rd_data_w;

   exu_cfg_pkg::data_t rf [32];
   // register values in program order, taken from the vector expectations
   exu_cfg_pkg::data_t exp_rf [32];
   logic               link_wen_e;
   logic [31:0]        lfsr;
   logic [31:0]        vec [max_lines][13];
   int                 num_lines;
   logic               loaded;
   int                 cycle;
   int                 errors;
   int                 checks;
   int                 q_line [$];
   int                 q_cycle [$];
   exu_cfg_pkg::reg_addr_t q_rd [$];
   exu_cfg_pkg::data_t q_data [$];

   exu_ecl dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #clk_half clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   //////////////////////////////////////////////////////////////////////
   // unit and register file models
   //////////////////////////////////////////////////////////////////////

   // write-through read with r0 held at zero
   function automatic exu_cfg_pkg::data_t rf_read(input exu_cfg_pkg::reg_addr_t a);
      if (a == '0) return '0;
      if (rf_wen_w && rf_rd_w == a) return rf_rd_data_w;
      return rf[a];
   endfunction

   always @(posedge clk) begin
      if (rf_wen_w && rf_rd_w != '0) rf[rf_rd_w] <= rf_rd_data_w;
      // branch unit keeps the link enable of the branch it receives
      link_wen_e <= valid_d && unit_d == exu_op_pkg::unit_bru && rf_wen_d;
   end

   always_comb begin
      rs1_data_d   = rf_read(rs1_d);
      rs2_data_d   = rf_read(rs2_d);
      alu_res_e    = alu_a_e + alu_b_e;
      bru_taken_e  = bru_valid_e && (bru_a_e == bru_b_e);
      bru_target_e = bru_pc_e + bru_offs_e;
      bru_link_e   = bru_pc_e + 32'd4;
      bru_wen_e    = bru_valid_e & link_wen_e;
   end

   // galois lfsr stepped once per bit taken
   function automatic int take_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         v = v * 2 + (lfsr[0] ? 1 : 0);
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
      end
      return v;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////

   task automatic check_data(input string name, input exu_cfg_pkg::data_t exp,
                             input exu_cfg_pkg::data_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input exu_cfg_pkg::reg_addr_t exp,
                             input exu_cfg_pkg::reg_addr_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[ERROR] %s: expected r%0d, actual r%0d", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic check_code(input string name, input logic [exu_op_pkg::code_w-1:0] exp,
                             input logic [exu_op_pkg::code_w-1:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // operation codes reach E unchanged
   task automatic check_codes(input int i);
      check_code($sformatf("line %0d alu_code_e", i), exu_op_pkg::alu_code_t'(i),
                 alu_code_e);
      check_code($sformatf("line %0d bru_code_e", i), exu_op_pkg::bru_code_t'(i + 5),
                 bru_code_e);
      check_code($sformatf("line %0d lsu_code_e", i), exu_op_pkg::lsu_code_t'(i + 10),
                 lsu_code_e);
   endtask

   task automatic expect_wb(input int ln, input exu_cfg_pkg::reg_addr_t rd,
                            input exu_cfg_pkg::data_t data, input int at_cycle);
      q_line.push_back(ln);
      q_rd.push_back(rd);
      q_data.push_back(data);
      q_cycle.push_back(at_cycle);
   endtask

   // every write-back must match the oldest pending one
   always @(negedge clk) begin
      if (!rst && rf_wen_w) begin
         if (q_line.size() == 0) begin
            errors++;
            $display("unexpected write-back to r%0d with %h", rf_rd_w, rf_rd_data_w);
         end else begin
            check_addr($sformatf("line %0d wb rd", q_line[0]), q_rd.pop_front(), rf_rd_w);
            check_data($sformatf("line %0d wb data", q_line[0]), q_data.pop_front(),
                       rf_rd_data_w);
            checks++;
            if (q_cycle[0] != cycle) begin
               errors++;
               $display("[ERROR] line %0d wb cycle: expected %0d, actual %0d",
                        q_line[0], q_cycle[0], cycle);
            end
            void'(q_cycle.pop_front());
            void'(q_line.pop_front());
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   // vector columns kind nogap a_pc b_imm dbl wen rd rj rk pc imm expect aux
   task automatic present(input int i);
      valid_d       = 1'b1;
      unit_d        = exu_op_pkg::unit_e'(vec[i][0][1:0]);
      alu_code_d    = exu_op_pkg::alu_code_t'(i);
      bru_code_d    = exu_op_pkg::bru_code_t'(i + 5);
      lsu_code_d    = exu_op_pkg::lsu_code_t'(i + 10);
      a_pc_d        = vec[i][2][0];
      b_imm_d       = vec[i][3][0];
      double_read_d = vec[i][4][0];
      rf_wen_d      = vec[i][5][0];
      rf_target_d   = vec[i][6][4:0];
      inst_d        = {17'd0, vec[i][8][4:0], vec[i][7][4:0], 5'd0};
      pc_d          = vec[i][9];
      imm_d         = vec[i][10];
      br_offs_d     = vec[i][10];
   endtask

   // sits in D while a taken branch is in E
   task automatic present_shadow();
      valid_d     = 1'b1;
      unit_d      = exu_op_pkg::unit_alu;
      a_pc_d      = 1'b0;
      b_imm_d     = 1'b1;
      rf_wen_d    = 1'b1;
      rf_target_d = 5'd31;
      inst_d      = '0;
      imm_d       = 32'h0000dead;
   endtask

   task automatic run_alu_bru(input int i);
      logic is_bru;
      logic taken;
      is_bru = (vec[i][0] == 32'd1);
      taken  = vec[i][12][0];
      present(i);
      if (vec[i][5][0]) expect_wb(i, vec[i][6][4:0], vec[i][11], cycle + 3);
      @(negedge clk);
      valid_d = 1'b0;
      check_bit($sformatf("line %0d alu_valid_e", i), ~is_bru, alu_valid_e);
      check_bit($sformatf("line %0d bru_valid_e", i), is_bru, bru_valid_e);
      check_codes(i);
      if (is_bru) begin
         check_bit($sformatf("line %0d br_taken_e", i), taken, br_taken_e);
         if (taken) begin
            check_data($sformatf("line %0d br_pc_e", i), vec[i][9] + vec[i][10], br_pc_e);
            present_shadow();
            @(negedge clk);
            valid_d = 1'b0;
            check_bit($sformatf("line %0d killed alu_valid_e", i), 1'b0, alu_valid_e);
         end
      end
   endtask

   task automatic run_load(input int i);
      int delay;
      present(i);
      #1;
      check_bit($sformatf("line %0d stall at dispatch", i), 1'b1, stall_req);
      @(negedge clk);
      valid_d = 1'b0;
      check_bit($sformatf("line %0d lsu_valid_e", i), 1'b1, lsu_valid_e);
      check_data($sformatf("line %0d lsu_offset_e", i), vec[i][12], lsu_offset_e);
      check_data($sformatf("line %0d lsu_base_e", i), exp_rf[vec[i][7][4:0]], lsu_base_e);
      check_data($sformatf("line %0d lsu_wdata_e", i), exp_rf[vec[i][8][4:0]],
                 lsu_wdata_e);
      check_addr($sformatf("line %0d lsu_rd_e", i), vec[i][6][4:0], lsu_rd_e);
      check_bit($sformatf("line %0d lsu_wen_e", i), vec[i][5][0], lsu_wen_e);
      check_codes(i);
      check_bit($sformatf("line %0d stall in E", i), 1'b1, stall_req);
      delay = 1 + take_bits(2);
      repeat (delay - 1) begin
         @(negedge clk);
         check_bit($sformatf("line %0d stall waiting", i), 1'b1, stall_req);
      end
      @(negedge clk);
      lsu_rdata_valid_m = 1'b1;
      lsu_rdata_m       = vec[i][11];
      lsu_rd_m          = vec[i][6][4:0];
      lsu_wen_m         = vec[i][5][0];
      if (vec[i][5][0]) expect_wb(i, vec[i][6][4:0], vec[i][11], cycle + 1);
      check_bit($sformatf("line %0d stall at return", i), 1'b1, stall_req);
      @(negedge clk);
      lsu_rdata_valid_m = 1'b0;
      lsu_wen_m         = 1'b0;
      check_bit($sformatf("line %0d stall after return", i), 1'b0, stall_req);
   endtask

   task automatic load_vectors();
      int    fd;
      int    rc;
      string line;
      logic [31:0] f [13];
      fd = $fopen("testbench/exu_ecl_vectors.txt", "r");
      num_lines = 0;
      if (fd == 0) begin
         $display("could not open the vector file");
      end else begin
         while (!$feof(fd) && num_lines < max_lines) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != 8'h23) begin
               rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
                            f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                            f[12]);
               if (rc == 13) begin
                  vec[num_lines] = f;
                  num_lines++;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   initial begin
      int gap;
      loaded = 1'b0;
      rst = 1'b1;
      valid_d = 1'b0;
      inst_d = '0;
      pc_d = '0;
      unit_d = exu_op_pkg::unit_alu;
      alu_code_d = '0;
      bru_code_d = '0;
      lsu_code_d = '0;
      {a_pc_d, b_imm_d, rd2rj_d, rd_read_d, double_read_d, rf_wen_d} = '0;
      rf_target_d = '0;
      imm_d = '0;
      br_offs_d = '0;
      lsu_rdata_valid_m = 1'b0;
      lsu_rdata_m = '0;
      lsu_rd_m = '0;
      lsu_wen_m = 1'b0;
      for (int r = 0; r < 32; r++) begin
         rf[r] = '0;
         exp_rf[r] = '0;
      end
      link_wen_e = 1'b0;
      cycle = 0;
      errors = 0;
      checks = 0;
      lfsr = lfsr_seed;
      load_vectors();
      if (num_lines == 0) begin
         errors++;
         $display("no vector lines were read");
      end
      loaded = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_bit("reset rf_wen_w", 1'b0, rf_wen_w);
      check_bit("reset stall_req", 1'b0, stall_req);
      check_bit("reset alu_valid_e", 1'b0, alu_valid_e);
      check_bit("reset bru_valid_e", 1'b0, bru_valid_e);
      check_bit("reset lsu_valid_e", 1'b0, lsu_valid_e);
      for (int i = 0; i < num_lines; i++) begin
         if (vec[i][1] == 32'd0) begin
            gap = take_bits(2);
            repeat (gap) @(negedge clk);
         end
         if (vec[i][0] == 32'd2) run_load(i);
         else run_alu_bru(i);
         if (vec[i][5][0] && vec[i][6][4:0] != 5'd0) begin
            exp_rf[vec[i][6][4:0]] = vec[i][11];
         end
      end
      repeat (8) @(negedge clk);
      if (q_line.size() != 0) begin
         errors++;
         $display("%0d expected write-backs never happened", q_line.size());
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // watchdog sized from the number of vector lines
   initial begin
      wait (loaded);
      repeat ((num_lines + 1) * cycles_per_line) @(posedge clk);
      $display("timeout, the run did not finish in time");
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: testbench/exu_ecl_vectors.txt
# kind(0 alu 1 branch 2 load) nogap a_pc b_imm dbl wen rd rj rk pc imm expect aux
# expect is the write-back value; aux is taken for branches and lsu offset for loads
0 0 0 1 0 1 01 00 00 00001000 00000010 00000010 00000000
0 1 0 1 0 1 02 01 00 00001004 00000005 00000015 00000000
0 1 0 0 0 1 03 01 02 00001008 00000000 00000025 00000000
0 0 1 1 0 1 04 00 00 00002000 00000100 00002100 00000000
0 0 0 1 0 1 00 03 00 0000200c 00000001 00000026 00000000
0 1 0 1 0 1 05 00 00 00002010 00000007 00000007 00000000
0 1 0 0 0 1 06 05 05 00002014 00000000 0000000e 00000000
1 0 0 0 0 1 07 01 01 00003000 00000040 00003004 00000001
1 0 0 0 0 0 00 01 02 00003100 00000020 00000000 00000000
0 1 0 1 0 1 08 07 00 00003104 00000001 00003005 00000000
2 0 0 0 0 1 09 01 00 00003200 00000008 cafe0001 00000008
2 0 0 0 1 1 0a 01 02 00003204 00000004 12345678 00000015
0 1 0 0 0 1 0b 0a 09 00003208 00000000 dd325679 00000000
2 0 0 0 0 0 00 02 00 00003300 00000010 00000000 00000010
0 1 0 1 0 1 0c 0b 00 00003304 00000001 dd32567a 00000000
1 0 0 0 0 0 00 05 05 00003400 00000010 00000000 00000001
0 0 0 0 0 1 0d 0c 06 00003500 00000000 dd325688 00000000
0 0 0 1 0 1 0e 1f 00 00003504 00000001 00000001 00000000

// File: verilog.f
rtl/exu_cfg_pkg.sv
rtl/exu_op_pkg.sv
rtl/exu_dispatch.sv
rtl/exu_bypass.sv
rtl/exu_writeback.sv
rtl/exu_ecl.sv
testbench/exu_ecl_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --top-module exu_ecl_tb -f verilog.f -o exu_ecl_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/exu_ecl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test failures found" "$LOG"; then
   exit 1
fi
if ! grep -q "All tests passed!" "$LOG"; then
   echo "no result found in $LOG"
   exit 1
fi
exit 0
